/* src/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

        // access width, low two bits of funct3
        typedef enum logic [1:0] {
                MEM_BYTE = 2'b00,  // lb/lbu/sb
                MEM_HALF = 2'b01,  // lh/lhu/sh
                MEM_WORD = 2'b10   // lw/sw
        } mem_size_e;

        // request from the core's memory stage
        typedef struct packed {
                logic [31:0] addr;         // byte address
                logic        store;        // 1 store, 0 load
                mem_size_e   size;
                logic        unsigned_ld;  // lbu / lhu
                logic [31:0] wdata;        // right-aligned store data
        } lsu_req_t;

        // response back to the core, in request order
        typedef struct packed {
                logic [31:0] rdata;  // extended load result, zero for stores
                logic        err;    // misaligned or out of range
                logic        store;  // echo of the request kind
        } lsu_rsp_t;

        // default ram depth in 32-bit words
        localparam int unsigned DEFAULT_DEPTH_WORDS = 256;

endpackage

`default_nettype wire

/* src/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

// one-entry valid/ready register slice
module pipe_reg #(
        parameter type T = logic
) (
        input  wire logic clk,
        input  wire logic reset_i,

        input  wire logic in_valid_i,
        output      logic in_ready_o,
        input  wire T     in_data_i,

        output      logic out_valid_o,
        input  wire logic out_ready_i,
        output      T     out_data_o
);

        logic valid_q;
        T     data_q;

        // free slot, or the held entry leaves this cycle
        assign in_ready_o = ~valid_q | out_ready_i;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        valid_q <= 1'b0;
                end else if (in_ready_o) begin
                        valid_q <= in_valid_i;
                end
        end

        // payload only moves on an actual handshake
        always_ff @(posedge clk) begin
                if (in_valid_i && in_ready_o) begin
                        data_q <= in_data_i;
                end
        end

        assign out_valid_o = valid_q;
        assign out_data_o  = data_q;

endmodule

`default_nettype wire

/* src/lsu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_stage #(
        parameter int unsigned DEPTH_WORDS = dmem_pkg::DEFAULT_DEPTH_WORDS
) (
        // held request from the request slice
        input  wire logic                 req_valid_i,
        output      logic                 req_ready_o,
        input  wire dmem_pkg::lsu_req_t   req_i,

        // result into the response slice
        output      logic                 rsp_valid_o,
        input  wire logic                 rsp_ready_i,
        output      dmem_pkg::lsu_rsp_t   rsp_o,

        // memory side
        output      logic [$clog2(DEPTH_WORDS)-1:0] mem_word_addr_o,
        output      logic                 mem_wr_o,
        output      dmem_pkg::mem_size_e  mem_size_o,
        output      logic [1:0]           mem_byte_off_o,
        output      logic                 mem_unsigned_o,
        output      logic [31:0]          mem_wdata_o,
        input  wire logic [31:0]          mem_rdata_i
);

        localparam int unsigned AW = $clog2(DEPTH_WORDS);

        logic fire;
        logic misaligned;
        logic in_range;
        logic err;

        // natural alignment per access size
        always_comb begin
                case (req_i.size)
                        dmem_pkg::MEM_BYTE: misaligned = 1'b0;
                        dmem_pkg::MEM_HALF: misaligned = req_i.addr[0];
                        dmem_pkg::MEM_WORD: misaligned = |req_i.addr[1:0];
                        default:            misaligned = 1'b1;  // funct3 size 11 is not rv32
                endcase
        end

        // whole word index, upper bits included
        assign in_range = {2'b00, req_i.addr[31:2]} < DEPTH_WORDS;
        assign err      = misaligned | ~in_range;

        // the access completes when the result has somewhere to go
        assign fire        = req_valid_i & rsp_ready_i;
        assign req_ready_o = rsp_ready_i;
        assign rsp_valid_o = req_valid_i;

        assign mem_word_addr_o = req_i.addr[AW+1:2];
        assign mem_size_o      = req_i.size;
        assign mem_byte_off_o  = req_i.addr[1:0];
        assign mem_unsigned_o  = req_i.unsigned_ld;
        assign mem_wdata_o     = req_i.wdata;
        assign mem_wr_o        = fire & req_i.store & ~err;  // illegal stores write nothing

        always_comb begin
                rsp_o.err   = err;
                rsp_o.store = req_i.store;
                if (err || req_i.store) begin
                        rsp_o.rdata = 32'd0;
                end else begin
                        rsp_o.rdata = mem_rdata_i;
                end
        end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

// word ram, async read, byte-lane write on the clock
module data_mem #(
        parameter int unsigned DEPTH_WORDS = dmem_pkg::DEFAULT_DEPTH_WORDS
) (
        input  wire logic                          clk,
        input  wire logic [$clog2(DEPTH_WORDS)-1:0] word_addr_i,
        input  wire logic                          wr_i,
        input  wire dmem_pkg::mem_size_e           size_i,
        input  wire logic [1:0]                    byte_off_i,
        input  wire logic                          unsigned_i,
        input  wire logic [31:0]                   wdata_i,
        output      logic [31:0]                   rdata_o
);

        logic [3:0][7:0] mem [DEPTH_WORDS];

        logic [3:0]      lane_en;
        logic [3:0][7:0] wr_lanes;
        logic [31:0]     rd_word;
        logic [7:0]      rd_byte;
        logic [15:0]     rd_half;

        // lane enables and store data spread to the addressed lanes
        always_comb begin
                case (size_i)
                        dmem_pkg::MEM_BYTE: begin
                                lane_en  = 4'b0001 << byte_off_i;
                                wr_lanes = {4{wdata_i[7:0]}};
                        end
                        dmem_pkg::MEM_HALF: begin
                                lane_en  = byte_off_i[1] ? 4'b1100 : 4'b0011;
                                wr_lanes = {2{wdata_i[15:0]}};
                        end
                        dmem_pkg::MEM_WORD: begin
                                lane_en  = 4'b1111;
                                wr_lanes = wdata_i;
                        end
                        default: begin
                                lane_en  = 4'b0000;  // no lanes for an unknown size
                                wr_lanes = wdata_i;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (wr_i) begin
                        for (int i = 0; i < 4; i++) begin
                                if (lane_en[i]) begin
                                        mem[word_addr_i][i] <= wr_lanes[i];
                                end
                        end
                end
        end

        assign rd_word = mem[word_addr_i];

        // addressed byte and halfword of the word
        assign rd_byte = rd_word[byte_off_i*8 +: 8];
        assign rd_half = byte_off_i[1] ? rd_word[31:16] : rd_word[15:0];

        always_comb begin
                case (size_i)
                        dmem_pkg::MEM_BYTE: begin
                                if (unsigned_i) begin
                                        rdata_o = {24'd0, rd_byte};
                                end else begin
                                        rdata_o = {{24{rd_byte[7]}}, rd_byte};
                                end
                        end
                        dmem_pkg::MEM_HALF: begin
                                if (unsigned_i) begin
                                        rdata_o = {16'd0, rd_half};
                                end else begin
                                        rdata_o = {{16{rd_half[15]}}, rd_half};
                                end
                        end
                        default: rdata_o = rd_word;  // lw as is
                endcase
        end

endmodule

`default_nettype wire

/* src/dmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_top #(
        parameter int unsigned DEPTH_WORDS = dmem_pkg::DEFAULT_DEPTH_WORDS
) (
        input  wire logic               clk,
        input  wire logic               reset_i,

        // request channel from the core
        input  wire logic               req_valid_i,
        output      logic               req_ready_o,
        input  wire dmem_pkg::lsu_req_t req_i,

        // response channel back to the core
        output      logic               rsp_valid_o,
        input  wire logic               rsp_ready_i,
        output      dmem_pkg::lsu_rsp_t rsp_o
);

        localparam int unsigned AW = $clog2(DEPTH_WORDS);

        // held request
        dmem_pkg::lsu_req_t  held_req;
        logic                held_valid;
        logic                held_ready;

        // result heading for the response slice
        dmem_pkg::lsu_rsp_t  lsu_rsp;
        logic                lsu_rsp_valid;
        logic                rsp_slice_ready;

        // memory port
        logic [AW-1:0]       mem_word_addr;
        logic                mem_wr;
        dmem_pkg::mem_size_e mem_size;
        logic [1:0]          mem_byte_off;
        logic                mem_unsigned;
        logic [31:0]         mem_wdata;
        logic [31:0]         mem_rdata;

        pipe_reg #(.T(dmem_pkg::lsu_req_t)) req_slice (
                .clk         (clk),
                .reset_i     (reset_i),
                .in_valid_i  (req_valid_i),
                .in_ready_o  (req_ready_o),
                .in_data_i   (req_i),
                .out_valid_o (held_valid),
                .out_ready_i (held_ready),
                .out_data_o  (held_req)
        );

        lsu_stage #(.DEPTH_WORDS(DEPTH_WORDS)) lsu_stage_i (
                .req_valid_i     (held_valid),
                .req_ready_o     (held_ready),
                .req_i           (held_req),
                .rsp_valid_o     (lsu_rsp_valid),
                .rsp_ready_i     (rsp_slice_ready),
                .rsp_o           (lsu_rsp),
                .mem_word_addr_o (mem_word_addr),
                .mem_wr_o        (mem_wr),
                .mem_size_o      (mem_size),
                .mem_byte_off_o  (mem_byte_off),
                .mem_unsigned_o  (mem_unsigned),
                .mem_wdata_o     (mem_wdata),
                .mem_rdata_i     (mem_rdata)
        );

        data_mem #(.DEPTH_WORDS(DEPTH_WORDS)) data_mem_i (
                .clk         (clk),
                .word_addr_i (mem_word_addr),
                .wr_i        (mem_wr),
                .size_i      (mem_size),
                .byte_off_i  (mem_byte_off),
                .unsigned_i  (mem_unsigned),
                .wdata_i     (mem_wdata),
                .rdata_o     (mem_rdata)
        );

        pipe_reg #(.T(dmem_pkg::lsu_rsp_t)) rsp_slice (
                .clk         (clk),
                .reset_i     (reset_i),
                .in_valid_i  (lsu_rsp_valid),
                .in_ready_o  (rsp_slice_ready),
                .in_data_i   (lsu_rsp),
                .out_valid_o (rsp_valid_o),
                .out_ready_i (rsp_ready_i),
                .out_data_o  (rsp_o)
        );

endmodule

`default_nettype wire

/* tests/dmem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// bound into dmem_top
module dmem_assertions #(
        parameter int unsigned DEPTH_WORDS = dmem_pkg::DEFAULT_DEPTH_WORDS
) (
        input wire logic               clk,
        input wire logic               reset_i,
        input wire logic               rsp_valid_i,
        input wire logic               rsp_ready_i,
        input wire dmem_pkg::lsu_rsp_t rsp_i,
        input wire logic               mem_wr_i,    // internal write strobe
        input wire dmem_pkg::lsu_req_t held_req_i   // request held in the request slice
);

        logic held_misaligned;
        logic held_out_of_range;

        // legality of the held request, from its address and size
        assign held_misaligned = (held_req_i.size == dmem_pkg::MEM_HALF && held_req_i.addr[0])
                || (held_req_i.size == dmem_pkg::MEM_WORD && held_req_i.addr[1:0] != 2'b00);
        assign held_out_of_range = held_req_i.addr >= DEPTH_WORDS * 4;

        // response slice empties on reset
        a_rsp_idle_after_reset: assert property (
                @(posedge clk) reset_i |=> !rsp_valid_i
        ) else $error("response valid in the cycle after reset");

        // a stalled response keeps its valid and payload
        a_rsp_stable_when_stalled: assert property (
                @(posedge clk) disable iff (reset_i)
                rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i)
        ) else $error("response changed while stalled");

        a_no_write_on_err: assert property (
                @(posedge clk) disable iff (reset_i)
                mem_wr_i |-> !(held_misaligned || held_out_of_range)
        ) else $error("memory write for an access with err set");

        // errors and stores return zero data
        a_err_rdata_zero: assert property (
                @(posedge clk) disable iff (reset_i)
                rsp_valid_i && (rsp_i.err || rsp_i.store) |-> rsp_i.rdata == 32'd0
        ) else $error("nonzero rdata on an error or store response");

endmodule

`default_nettype wire

/* tests/dmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

        localparam int CLK_PERIOD  = 10;
        localparam int DEPTH_WORDS = 256;
        localparam int unsigned MEM_BYTES = DEPTH_WORDS * 4;

        localparam int RAND_WORDS = 32;   // words 32..63 for the random mix
        localparam int RAND_OPS   = 200;
        localparam int READY_LEN  = 512;
        // requests per test, summed for the watchdog
        localparam int N_REQS      = 16 + 18 + 26 + 12 + RAND_WORDS + RAND_OPS;
        localparam int WD_MARGIN   = 200;  // cycles
        localparam int DRAIN_LIMIT = 1000;

        logic               clk;
        logic               reset_i;
        logic               req_valid_i;
        logic               req_ready_o;
        dmem_pkg::lsu_req_t req_i;
        logic               rsp_valid_o;
        logic               rsp_ready_i;
        dmem_pkg::lsu_rsp_t rsp_o;

        logic [7:0]         model_mem [1024];     // byte model of the ram
        dmem_pkg::lsu_rsp_t exp_q [$];            // expected responses, in order
        dmem_pkg::lsu_req_t rand_reqs [256];
        logic               ready_pat [READY_LEN];
        logic               toggle_on;
        logic [8:0]         pat_idx;
        integer             seed;

        dmem_top #(.DEPTH_WORDS(DEPTH_WORDS)) dut_i (
                .clk         (clk),
                .reset_i     (reset_i),
                .req_valid_i (req_valid_i),
                .req_ready_o (req_ready_o),
                .req_i       (req_i),
                .rsp_valid_o (rsp_valid_o),
                .rsp_ready_i (rsp_ready_i),
                .rsp_o       (rsp_o)
        );

        bind dmem_top dmem_assertions #(.DEPTH_WORDS(DEPTH_WORDS)) dmem_assertions_i (
                .clk         (clk),
                .reset_i     (reset_i),
                .rsp_valid_i (rsp_valid_o),
                .rsp_ready_i (rsp_ready_i),
                .rsp_i       (rsp_o),
                .mem_wr_i    (mem_wr),
                .held_req_i  (held_req)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        initial begin
                #(CLK_PERIOD * (N_REQS * 20 + WD_MARGIN));
                $display("timeout: the tests did not finish in the allowed time");
                $display("STATUS: FAIL");
                $fatal(1, "watchdog expired");
        end

        // response back-pressure, random only while the pattern is switched on
        initial begin
                rsp_ready_i = 1'b1;
                pat_idx     = 9'd0;
                forever begin
                        @(negedge clk);
                        if (toggle_on) begin
                                rsp_ready_i = ready_pat[pat_idx];
                                pat_idx     = pat_idx + 9'd1;  // wraps at 512
                        end else begin
                                rsp_ready_i = 1'b1;
                        end
                end
        end

        task automatic check_val(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
                if (actual !== expected) begin
                        $display("ERR %0t: %s: got %h, expected %h", $time, what, actual, expected);
                        $display("STATUS: FAIL");
                        $fatal(1, "value mismatch");
                end
        endtask

        // compare every accepted response against the head of the queue
        always @(posedge clk) begin
                dmem_pkg::lsu_rsp_t exp;
                if (!reset_i && rsp_valid_o && rsp_ready_i) begin
                        if (exp_q.size() == 0) begin
                                $display("a response arrived with no request outstanding");
                                $display("STATUS: FAIL");
                                $fatal(1, "unexpected response");
                        end else begin
                                exp = exp_q.pop_front();
                                check_val("rsp rdata", rsp_o.rdata, exp.rdata);
                                check_val("rsp err", {31'd0, rsp_o.err}, {31'd0, exp.err});
                                check_val("rsp store", {31'd0, rsp_o.store}, {31'd0, exp.store});
                        end
                end
        end

        function automatic dmem_pkg::lsu_req_t make_req(input logic store,
                                                        input dmem_pkg::mem_size_e sz,
                                                        input logic uns,
                                                        input logic [31:0] addr,
                                                        input logic [31:0] data);
                dmem_pkg::lsu_req_t r;
                r.addr        = addr;
                r.store       = store;
                r.size        = sz;
                r.unsigned_ld = uns;
                r.wdata       = data;
                return r;
        endfunction

        // fill value that depends on every address bit
        function automatic logic [31:0] fill_word(input logic [31:0] addr);
                return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e3779b9;
        endfunction

        // apply the access rules to the byte model and give the expected response
        task automatic model_access(input dmem_pkg::lsu_req_t r, output dmem_pkg::lsu_rsp_t e);
                logic        misaligned;
                logic [9:0]  b;
                logic [15:0] h;
                misaligned = (r.size == dmem_pkg::MEM_HALF && r.addr[0]) ||
                             (r.size == dmem_pkg::MEM_WORD && r.addr[1:0] != 2'b00);
                b       = r.addr[9:0];
                e.store = r.store;
                e.err   = misaligned || (r.addr >= MEM_BYTES);
                e.rdata = 32'd0;
                if (!e.err && r.store) begin
                        model_mem[b] = r.wdata[7:0];
                        if (r.size != dmem_pkg::MEM_BYTE) begin
                                model_mem[b + 10'd1] = r.wdata[15:8];
                        end
                        if (r.size == dmem_pkg::MEM_WORD) begin
                                model_mem[b + 10'd2] = r.wdata[23:16];
                                model_mem[b + 10'd3] = r.wdata[31:24];
                        end
                end else if (!e.err) begin
                        h = {model_mem[b + 10'd1], model_mem[b]};
                        case (r.size)
                                dmem_pkg::MEM_BYTE: begin
                                        e.rdata = r.unsigned_ld ? {24'd0, h[7:0]}
                                                                : {{24{h[7]}}, h[7:0]};
                                end
                                dmem_pkg::MEM_HALF: begin
                                        e.rdata = r.unsigned_ld ? {16'd0, h} : {{16{h[15]}}, h};
                                end
                                default: begin
                                        e.rdata = {model_mem[b + 10'd3], model_mem[b + 10'd2], h};
                                end
                        endcase
                end
        endtask

        // present one request and hold it until accepted, starting at a falling edge
        task automatic issue(input dmem_pkg::lsu_req_t r);
                dmem_pkg::lsu_rsp_t e;
                logic               accepted;
                model_access(r, e);
                exp_q.push_back(e);
                req_i       = r;
                req_valid_i = 1'b1;
                accepted    = 1'b0;
                while (!accepted) begin
                        @(posedge clk);
                        accepted = req_ready_o;
                end
                @(negedge clk);
                req_valid_i = 1'b0;
        endtask

        task automatic store_op(input dmem_pkg::mem_size_e sz, input logic [31:0] addr,
                                input logic [31:0] data);
                issue(make_req(1'b1, sz, 1'b0, addr, data));
        endtask

        task automatic load_op(input dmem_pkg::mem_size_e sz, input logic uns,
                               input logic [31:0] addr);
                issue(make_req(1'b0, sz, uns, addr, 32'd0));
        endtask

        // wait for all outstanding responses
        task automatic drain();
                int waited;
                waited = 0;
                while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
                        @(negedge clk);
                        waited = waited + 1;
                end
                if (exp_q.size() != 0) begin
                        $display("responses still missing after %0d cycles", DRAIN_LIMIT);
                        $display("STATUS: FAIL");
                        $fatal(1, "responses lost");
                end
        endtask

        task automatic test_word_rw();
                int i;
                for (i = 0; i < 8; i++) begin
                        store_op(dmem_pkg::MEM_WORD, i * 4, $random(seed));
                end
                for (i = 0; i < 8; i++) begin
                        load_op(dmem_pkg::MEM_WORD, 1'b0, i * 4);
                end
                drain();
        endtask

        task automatic test_sub_word_stores();
                int i;
                for (i = 16; i < 22; i++) begin
                        store_op(dmem_pkg::MEM_WORD, i * 4, fill_word(i * 4));
                end
                for (i = 0; i < 4; i++) begin
                        store_op(dmem_pkg::MEM_BYTE, (16 + i) * 4 + i, 32'hffff_ff00 | i);  // lane i
                end
                store_op(dmem_pkg::MEM_HALF, 20 * 4, 32'h1234_beef);
                store_op(dmem_pkg::MEM_HALF, 21 * 4 + 2, 32'h5678_c0de);
                for (i = 16; i < 22; i++) begin
                        load_op(dmem_pkg::MEM_WORD, 1'b0, i * 4);
                end
                drain();
        endtask

        task automatic test_sub_word_loads();
                int w;
                int off;
                store_op(dmem_pkg::MEM_WORD, 10 * 4, 32'hf08a_7f93);
                store_op(dmem_pkg::MEM_WORD, 11 * 4, 32'h8001_ff7e);
                for (w = 10; w < 12; w++) begin
                        for (off = 0; off < 4; off++) begin
                                load_op(dmem_pkg::MEM_BYTE, 1'b0, w * 4 + off);  // lb
                                load_op(dmem_pkg::MEM_BYTE, 1'b1, w * 4 + off);  // lbu
                        end
                        for (off = 0; off < 4; off += 2) begin
                                load_op(dmem_pkg::MEM_HALF, 1'b0, w * 4 + off);
                                load_op(dmem_pkg::MEM_HALF, 1'b1, w * 4 + off);
                        end
                end
                drain();
        endtask

        task automatic test_errors();
                store_op(dmem_pkg::MEM_WORD, 32'h60, 32'hc0ff_ee11);
                store_op(dmem_pkg::MEM_HALF, 32'h61, 32'hdead_beef);
                store_op(dmem_pkg::MEM_WORD, 32'h62, 32'hdead_beef);
                store_op(dmem_pkg::MEM_WORD, 32'h63, 32'hdead_beef);
                load_op(dmem_pkg::MEM_WORD, 1'b0, 32'h61);
                load_op(dmem_pkg::MEM_HALF, 1'b0, 32'h63);
                load_op(dmem_pkg::MEM_HALF, 1'b1, 32'h61);
                store_op(dmem_pkg::MEM_WORD, MEM_BYTES, 32'h0bad_0bad);  // one word past the end
                load_op(dmem_pkg::MEM_WORD, 1'b0, MEM_BYTES);
                store_op(dmem_pkg::MEM_BYTE, 32'h8000_0000, 32'h0000_00aa);  // high bits set
                load_op(dmem_pkg::MEM_WORD, 1'b0, 32'h60);
                load_op(dmem_pkg::MEM_WORD, 1'b0, 32'h00);  // aliases of the bad stores
                drain();
        endtask

        task automatic test_random_mix();
                int                  i;
                logic [31:0]         r;
                logic [31:0]         d;
                logic [1:0]          off;
                dmem_pkg::mem_size_e sz;
                for (i = 0; i < RAND_OPS; i++) begin
                        r = $random(seed);
                        d = $random(seed);
                        case (r[2:1])
                                2'd0:    sz = dmem_pkg::MEM_BYTE;
                                2'd1:    sz = dmem_pkg::MEM_HALF;
                                default: sz = dmem_pkg::MEM_WORD;
                        endcase
                        off = r[10:9];
                        if (sz == dmem_pkg::MEM_HALF) begin
                                off = {r[10], 1'b0};
                        end else if (sz == dmem_pkg::MEM_WORD) begin
                                off = 2'b00;
                        end
                        if (r[14:11] == 4'd0) begin
                                off = r[10:9];  // now and then misaligned
                        end
                        rand_reqs[i[7:0]] = make_req(r[0], sz, r[3],
                                32'h80 + {25'd0, r[8:4], 2'b00} + {30'd0, off}, d);
                end
                for (i = 0; i < READY_LEN; i++) begin
                        r = $random(seed);
                        ready_pat[i[8:0]] = r[0];
                end
                for (i = 32; i < 32 + RAND_WORDS; i++) begin
                        store_op(dmem_pkg::MEM_WORD, i * 4, fill_word(i * 4));
                end
                drain();
                @(posedge clk);
                toggle_on = 1'b1;
                @(negedge clk);
                for (i = 0; i < RAND_OPS; i++) begin
                        issue(rand_reqs[i[7:0]]);
                end
                drain();
                @(posedge clk);
                toggle_on = 1'b0;
                @(negedge clk);
        endtask

        initial begin
                int i;
                seed        = 32'hf24eae29;
                reset_i     = 1'b1;
                req_valid_i = 1'b0;
                req_i       = '0;
                toggle_on   = 1'b0;
                for (i = 0; i < 1024; i++) begin
                        model_mem[i[9:0]] = 8'h00;
                end
                repeat (4) @(posedge clk);
                @(negedge clk);
                reset_i = 1'b0;

                test_word_rw();
                test_sub_word_stores();
                test_sub_word_loads();
                test_errors();
                test_random_mix();

                // idle with ready high, a duplicate would show up here
                repeat (4) @(negedge clk);
                check_val("rsp valid when idle", {31'd0, rsp_valid_o}, 32'd0);
                $display("STATUS: PASS");
                $finish;
        end

endmodule

`default_nettype wire

/* vlog.f */
src/dmem_pkg.sv
src/pipe_reg.sv
src/lsu_stage.sv
src/data_mem.sv
src/dmem_top.sv
tests/dmem_assertions.sv
tests/dmem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the data memory testbench with verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module dmem_tb \
        -f vlog.f -o Vdmem_tb \
        && ./obj_dir/Vdmem_tb > sim.log 2>&1 \
        || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0
